//--- Makefile
.PHONY: all build run lint clean

all: run

build: obj_dir/VtbTop

obj_dir/VtbTop: sources.f $(wildcard verilog/*) $(wildcard testbench/*)
	verilator --binary --assert --top-module tbTop -f sources.f

run: obj_dir/VtbTop
	obj_dir/VtbTop +verilator+error+limit+1000 > sim.log 2>&1; cat sim.log
	@if grep -q "tests failed" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "all tests passed" sim.log

lint:
	verilator --lint-only --timing --assert --top-module tbTop -f sources.f

clean:
	rm -rf obj_dir sim.log

//--- sources.f
+incdir+verilog
verilog/rvPkg.sv
verilog/aluUnit.sv
verilog/instrDecoder.sv
verilog/regFile.sv
verilog/hazardUnit.sv
verilog/riscvPipeline.sv
testbench/pipeline_sva.sv
testbench/storeChecker.sv
testbench/tbTop.sv

//--- testbench/pipeline_sva.sv
`default_nettype none

module pipelineSva
    import rvPkg::*;
(
    input wire           clk,
    input wire           rst_n,
    input wire           dcacheRen,
    input wire           dcacheWen,
    input wire           dcacheStall,
    input wire wordAddrT dcacheAddr,
    input wire wordT     dcacheWdata
);

    int errorCount = 0;

    strobesExclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(dcacheRen && dcacheWen))
        else begin
            errorCount++;
            $error("data cache read and write strobes high together");
        end

    // sync reset, so strobes are clear one edge after reset is seen
    strobesLowInReset: assert property (@(posedge clk)
        !rst_n |=> (!dcacheRen && !dcacheWen))
        else begin
            errorCount++;
            $error("data cache strobe high during reset");
        end

    requestSteady: assert property (@(posedge clk) disable iff (!rst_n)
        (dcacheStall && (dcacheRen || dcacheWen)) |=>
            ($stable(dcacheAddr) && $stable(dcacheWdata)))
        else begin
            errorCount++;
            $error("data cache request changed while stalled");
        end

endmodule

bind riscvPipeline pipelineSva svaCheck (
    .clk         (clk),
    .rst_n       (rst_n),
    .dcacheRen   (dcacheRen),
    .dcacheWen   (dcacheWen),
    .dcacheStall (dcacheStall),
    .dcacheAddr  (dcacheAddr),
    .dcacheWdata (dcacheWdata)
);

`default_nettype wire

//--- testbench/storeChecker.sv
`default_nettype none

module storeChecker
    import rvPkg::*;
(
    input wire           clk,
    input wire           rst_n,
    input wire           dcacheWen,
    input wire           dcacheStall,
    input wire wordAddrT dcacheAddr,
    input wire wordT     dcacheWdata
);

    string    curName;
    wordAddrT qAddr [$];
    wordT     qData [$];
    bit       active = 1'b0;
    bit       testBad;
    int       storeCount;
    int       testCount = 0;
    int       failCount = 0;

    task automatic beginTest(input string name);
        curName    = name;
        testBad    = 1'b0;
        storeCount = 0;
        qAddr.delete();
        qData.delete();
        active = 1'b1;
    endtask

    task automatic expectStore(input wordAddrT addr, input wordT data);
        qAddr.push_back(addr);
        qData.push_back(data);
    endtask

    task automatic printSummary();
        $display("summary: %0d run, %0d with errors", testCount, failCount);
    endtask

    always @(posedge clk) begin
        wordAddrT eAddr;
        wordT     eData;
        if (rst_n && active && dcacheWen && !dcacheStall) begin
            if (dcacheAddr == 30'h3F) begin // end of program
                if (qAddr.size() != 0) begin
                    $display("%s: %0d expected stores never appeared", curName, qAddr.size());
                    testBad = 1'b1;
                end
                testCount++;
                if (testBad) begin
                    failCount++;
                    $display("test %s: FAILED", curName);
                end else begin
                    $display("test %s: ok, %0d stores", curName, storeCount);
                end
                active = 1'b0;
            end else if (qAddr.size() == 0) begin
                $display("%s: unexpected extra store to word 0x%h with data 0x%h",
                         curName, dcacheAddr, dcacheWdata);
                testBad = 1'b1;
            end else begin
                eAddr = qAddr.pop_front();
                eData = qData.pop_front();
                storeCount++;
                if (eAddr != dcacheAddr || eData != dcacheWdata) begin
                    $display("Mismatch in %s: expected [0x%h]=0x%h, actual [0x%h]=0x%h",
                             curName, eAddr, eData, dcacheAddr, dcacheWdata);
                    testBad = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/tbTop.sv
`default_nettype none

`include "rv_defines.svh"

module tbTop;
    import rvPkg::*;

    localparam int NUM_TESTS = 9;
    localparam int MAX_PROG  = 32;
    localparam int MAX_EXP   = 12;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     icacheStall = 1'b0;
    logic     dcacheStall = 1'b0;
    wordAddrT icacheAddr;
    wordT     icacheRdata;
    logic     dcacheRen;
    logic     dcacheWen;
    wordAddrT dcacheAddr;
    wordT     dcacheWdata;
    wordT     dcacheRdata;
    logic     stallOn = 1'b0;

    wordT imem [64];
    wordT dmem [64];

    string    testName [NUM_TESTS];
    bit       stallFlag [NUM_TESTS];
    wordT     progMem [NUM_TESTS][MAX_PROG];
    int       progLen [NUM_TESTS];
    wordAddrT expAddr [NUM_TESTS][MAX_EXP];
    wordT     expData [NUM_TESTS][MAX_EXP];
    int       expCount [NUM_TESTS];
    int       nTests = 0;

    always #50 clk = ~clk;

    riscvPipeline uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .icacheAddr  (icacheAddr),
        .icacheRdata (icacheRdata),
        .icacheStall (icacheStall),
        .dcacheRen   (dcacheRen),
        .dcacheWen   (dcacheWen),
        .dcacheAddr  (dcacheAddr),
        .dcacheWdata (dcacheWdata),
        .dcacheRdata (dcacheRdata),
        .dcacheStall (dcacheStall)
    );

    storeChecker chk (
        .clk         (clk),
        .rst_n       (rst_n),
        .dcacheWen   (dcacheWen),
        .dcacheStall (dcacheStall),
        .dcacheAddr  (dcacheAddr),
        .dcacheWdata (dcacheWdata)
    );

    assign icacheRdata = imem[icacheAddr[5:0]];
    assign dcacheRdata = dcacheRen ? dmem[dcacheAddr[5:0]] : 32'hDEADBEEF; // data only on a read

    // data memory refilled while in reset, stall drawn every cycle
    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 64; i++) begin
                dmem[i] <= 32'hC0DE0000 + i;
            end
        end else if (dcacheWen && !dcacheStall) begin
            dmem[dcacheAddr[5:0]] <= dcacheWdata;
        end
        dcacheStall <= rst_n && stallOn && (($urandom % 4) == 0);
    end

    function automatic wordT encR(input int f7, input int rs2, input int rs1,
                                  input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], `OP_RTYPE};
    endfunction

    function automatic wordT encI(input int imm, input int rs1, input int f3,
                                  input int rd, input logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic wordT encS(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], `OP_STORE};
    endfunction

    function automatic wordT encB(input int imm, input int rs2, input int rs1, input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                `OP_BRANCH};
    endfunction

    function automatic wordT encJ(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], `OP_JAL};
    endfunction

    task automatic newTest(input string name, input bit stalled);
        testName[nTests]  = name;
        stallFlag[nTests] = stalled;
        progLen[nTests]   = 0;
        expCount[nTests]  = 0;
        nTests++;
    endtask

    task automatic emit(input wordT w);
        progMem[nTests-1][progLen[nTests-1]] = w;
        progLen[nTests-1]++;
    endtask

    task automatic want(input int addr, input wordT data);
        expAddr[nTests-1][expCount[nTests-1]] = addr[29:0];
        expData[nTests-1][expCount[nTests-1]] = data;
        expCount[nTests-1]++;
    endtask

    task automatic rerunStalled(input int src);
        newTest({testName[src], "_stalled"}, 1'b1);
        progLen[nTests-1]  = progLen[src];
        expCount[nTests-1] = expCount[src];
        progMem[nTests-1]  = progMem[src];
        expAddr[nTests-1]  = expAddr[src];
        expData[nTests-1]  = expData[src];
    endtask

    task automatic buildTable();
        newTest("alu_chain", 1'b0);
        emit(encI(100, 0, 0, 1, `OP_ITYPE));
        emit(encI(-7, 0, 0, 2, `OP_ITYPE));
        emit(encR(0, 2, 1, 0, 3));          // add
        emit(encR(32, 1, 3, 0, 4));         // sub
        emit(encR(0, 3, 4, 7, 5));          // and
        emit(encR(0, 2, 5, 6, 6));          // or
        emit(encR(0, 1, 6, 4, 7));          // xor
        emit(encR(0, 1, 7, 2, 8));          // slt
        emit(encR(0, 8, 1, 1, 9));          // sll
        emit(encR(0, 8, 2, 5, 10));         // srl
        emit(encR(32, 8, 2, 5, 11));        // sra
        emit(encI(12'h404, 7, 5, 13, `OP_ITYPE)); // srai by 4
        for (int r = 13; r >= 3; r--) begin
            if (r != 12) begin
                emit(encS(4 * r, r, 0));
            end
        end
        emit(encS(252, 0, 0));
        want(13, 32'hFFFFFFF9);
        want(11, 32'hFFFFFFFC);
        want(10, 32'h7FFFFFFC);
        want(9, 32'h000000C8);
        want(8, 32'h00000001);
        want(7, 32'hFFFFFF9D);
        want(6, 32'hFFFFFFF9);
        want(5, 32'h00000059);
        want(4, 32'hFFFFFFF9);
        want(3, 32'h0000005D);

        newTest("load_use", 1'b0);
        emit(encI(20, 0, 2, 1, `OP_LOAD));
        emit(encI(16, 1, 0, 2, `OP_ITYPE));
        emit(encS(8, 2, 0));
        emit(encI(24, 0, 2, 3, `OP_LOAD));
        emit(encS(12, 3, 0));
        emit(encI(28, 0, 2, 4, `OP_LOAD));
        emit(encI(-1, 4, 0, 5, `OP_ITYPE));
        emit(encR(0, 4, 5, 0, 6));
        emit(encS(16, 6, 0));
        emit(encS(252, 0, 0));
        want(2, 32'hC0DE0015);
        want(3, 32'hC0DE0006);
        want(4, 32'h81BC000D);

        newTest("branches", 1'b0);
        emit(encI(5, 0, 0, 1, `OP_ITYPE));
        emit(encI(5, 0, 0, 2, `OP_ITYPE));
        emit(encB(8, 2, 1, 0));             // beq taken
        emit(encS(4, 1, 0));
        emit(encI(9, 0, 0, 3, `OP_ITYPE));
        emit(encB(8, 1, 3, 1));             // bne taken
        emit(encS(8, 3, 0));
        emit(encB(8, 1, 3, 0));             // beq not taken
        emit(encS(12, 3, 0));
        emit(encB(8, 2, 1, 1));             // bne not taken
        emit(encS(16, 2, 0));
        emit(encI(12, 0, 2, 4, `OP_LOAD));
        emit(encB(8, 3, 4, 0));             // beq on a fresh load
        emit(encS(20, 4, 0));
        emit(encS(24, 4, 0));
        emit(encS(252, 0, 0));
        want(3, 32'd9);
        want(4, 32'd5);
        want(6, 32'd9);

        newTest("jumps", 1'b0);
        emit(encI(3, 0, 0, 1, `OP_ITYPE));
        emit(encJ(12, 5));
        emit(encS(4, 1, 0));
        emit(encS(8, 1, 0));
        emit(encS(12, 5, 0));
        emit(encI(40, 0, 0, 6, `OP_ITYPE));
        emit(encI(0, 6, 0, 7, `OP_JALR));
        emit(encS(16, 1, 0));
        emit(encS(20, 1, 0));
        emit(encS(24, 1, 0));
        emit(encS(28, 7, 0));
        emit(encS(252, 0, 0));
        want(3, 32'd8);
        want(7, 32'd28);

        newTest("x0_and_reset", 1'b0);
        emit(encI(55, 0, 0, 0, `OP_ITYPE));
        emit(encR(0, 0, 0, 0, 1));
        emit(encS(4, 0, 0));
        emit(encI(7, 0, 0, 2, `OP_ITYPE));
        emit(encR(0, 0, 2, 0, 3));
        emit(encS(8, 1, 0));
        emit(encS(12, 3, 0));
        emit(encS(252, 0, 0));
        want(1, 32'd0);
        want(2, 32'd0);
        want(3, 32'd7);

        for (int s = 0; s < 4; s++) begin
            rerunStalled(s);
        end
    endtask

    initial begin
        repeat (200 * NUM_TESTS) @(posedge clk);
        $display("watchdog expired before the last program finished");
        $display("tests failed");
        $finish;
    end

    initial begin
        void'($urandom(93813));
        rst_n = 1'b0;
        buildTable();
        for (int t = 0; t < nTests; t++) begin
            rst_n <= 1'b0;
            @(posedge clk); // checker has closed the previous test by this edge
            stallOn = stallFlag[t];
            for (int i = 0; i < 64; i++) begin
                imem[i] = (i < progLen[t]) ? progMem[t][i] : '0;
            end
            chk.beginTest(testName[t]);
            for (int e = 0; e < expCount[t]; e++) begin
                chk.expectStore(expAddr[t][e], expData[t][e]);
            end
            repeat (9) @(posedge clk);
            rst_n <= 1'b1;
            do begin
                @(posedge clk);
            end while (!(dcacheWen && !dcacheStall && dcacheAddr == 30'h3F));
        end
        rst_n <= 1'b0;
        @(posedge clk);
        chk.printSummary();
        if (chk.failCount == 0 && chk.testCount == NUM_TESTS &&
            uut.svaCheck.errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/aluUnit.sv
`default_nettype none

module aluUnit
    import rvPkg::*;
(
    input  wire wordT  opA,
    input  wire wordT  opB,
    input  wire aluOpT aluOp,
    output wordT       result
);

    logic [4:0] shamt;
    logic       lessThan;

    assign shamt    = opB[4:0];
    assign lessThan = $signed(opA) < $signed(opB);

    always_comb begin
        case (aluOp)
            aluAdd:  result = opA + opB;
            aluSub:  result = opA - opB;
            aluAnd:  result = opA & opB;
            aluOr:   result = opA | opB;
            aluXor:  result = opA ^ opB;
            aluSlt:  result = {31'b0, lessThan};
            aluSll:  result = opA << shamt;
            aluSrl:  result = opA >> shamt;
            aluSra:  result = $signed(opA) >>> shamt;
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/hazardUnit.sv
`default_nettype none

module hazardUnit
    import rvPkg::*;
(
    input  wire regAddrT decRs1,
    input  wire regAddrT decRs2,
    input  wire regAddrT exRs1,
    input  wire regAddrT exRs2,
    input  wire regAddrT exRd,
    input  wire regAddrT memRd,
    input  wire regAddrT wbRd,
    input  wire          exRegWrite,
    input  wire          exMemRead,
    input  wire          memRegWrite,
    input  wire          memMemRead,
    input  wire          wbRegWrite,
    input  wire          decIsBranch,
    output fwdSelT       fwdExA,
    output fwdSelT       fwdExB,
    output fwdSelT       fwdDecA,
    output fwdSelT       fwdDecB,
    output logic         stallDecode
);

    logic exHitsDec;
    logic memHitsDec;
    logic loadUse;
    logic branchDep;

    // memory stage is younger so it wins over writeback
    function automatic fwdSelT pickSource(
        input regAddrT src,
        input regAddrT mRd,
        input logic    mWrite,
        input regAddrT wRd,
        input logic    wWrite
    );
        if (mWrite && mRd != '0 && mRd == src) begin
            return fwdMem;
        end
        if (wWrite && wRd != '0 && wRd == src) begin
            return fwdWb;
        end
        return fwdNone;
    endfunction

    always_comb begin
        fwdExA  = pickSource(exRs1, memRd, memRegWrite, wbRd, wbRegWrite);
        fwdExB  = pickSource(exRs2, memRd, memRegWrite, wbRd, wbRegWrite);
        fwdDecA = pickSource(decRs1, memRd, memRegWrite, wbRd, wbRegWrite);
        fwdDecB = pickSource(decRs2, memRd, memRegWrite, wbRd, wbRegWrite);
    end

    assign exHitsDec  = exRd != '0 && (exRd == decRs1 || exRd == decRs2);
    assign memHitsDec = memRd != '0 && (memRd == decRs1 || memRd == decRs2);

    // load data is not ready until writeback
    assign loadUse = exMemRead && exHitsDec;

    // decode comparator has no path from execute, nor from a pending load
    assign branchDep = decIsBranch && ((exRegWrite && exHitsDec) || (memMemRead && memHitsDec));

    assign stallDecode = loadUse || branchDep;

endmodule

`default_nettype wire

//--- verilog/instrDecoder.sv
`default_nettype none

`include "rv_defines.svh"

module instrDecoder
    import rvPkg::*;
(
    input  wire wordT instr,
    output logic      isBranch,
    output logic      isJal,
    output logic      isJalr,
    output logic      memRead,
    output logic      memWrite,
    output logic      regWrite,
    output logic      aluSrcImm,
    output aluOpT     aluOp,
    output wordT      imm
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7b5;
    aluOpT      functOp;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];

    always_comb begin
        isBranch  = 1'b0;
        isJal     = 1'b0;
        isJalr    = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        regWrite  = 1'b0;
        aluSrcImm = 1'b0;
        case (opcode)
            `OP_RTYPE:  regWrite = 1'b1;
            `OP_ITYPE: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
            end
            `OP_LOAD: begin
                memRead   = 1'b1;
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
            end
            `OP_STORE: begin
                memWrite  = 1'b1;
                aluSrcImm = 1'b1;
            end
            `OP_BRANCH: isBranch = 1'b1;
            `OP_JAL: begin
                isJal    = 1'b1;
                regWrite = 1'b1;
            end
            `OP_JALR: begin
                isJalr   = 1'b1;
                regWrite = 1'b1;
            end
            default: ;  // unknown opcodes act as bubbles
        endcase
    end

    // shared by R and I types, sub only exists in R type
    always_comb begin
        case (funct3)
            3'b000:  functOp = (funct7b5 && opcode == `OP_RTYPE) ? aluSub : aluAdd;
            3'b001:  functOp = aluSll;
            3'b010:  functOp = aluSlt;
            3'b100:  functOp = aluXor;
            3'b101:  functOp = funct7b5 ? aluSra : aluSrl;
            3'b110:  functOp = aluOr;
            3'b111:  functOp = aluAnd;
            default: functOp = aluAdd;
        endcase
    end

    assign aluOp = (opcode == `OP_RTYPE || opcode == `OP_ITYPE) ? functOp : aluAdd;

    always_comb begin
        case (opcode)
            `OP_ITYPE, `OP_LOAD, `OP_JALR:
                imm = {{20{instr[31]}}, instr[31:20]};
            `OP_STORE:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            `OP_BRANCH:
                imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            `OP_JAL:
                imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/regFile.sv
`default_nettype none

`include "rv_defines.svh"

module regFile
    import rvPkg::*;
(
    input  wire          clk,
    input  wire          rst_n,
    input  wire regAddrT rs1,
    input  wire regAddrT rs2,
    input  wire regAddrT rd,
    input  wire          wrEn,
    input  wire wordT    wrData,
    output wordT         rdData1,
    output wordT         rdData2
);

    wordT regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && rd != '0) begin
            regs[rd] <= wrData; // x0 never written
        end
    end

    // write-through so decode sees this cycle's writeback
    assign rdData1 = (wrEn && rd != '0 && rd == rs1) ? wrData : regs[rs1];
    assign rdData2 = (wrEn && rd != '0 && rd == rs2) ? wrData : regs[rs2];

endmodule

`default_nettype wire

//--- verilog/riscvPipeline.sv
`default_nettype none

module riscvPipeline
    import rvPkg::*;
(
    input  wire       clk,
    input  wire       rst_n,
    output wordAddrT  icacheAddr,
    input  wire wordT icacheRdata,
    input  wire       icacheStall,
    output logic      dcacheRen,
    output logic      dcacheWen,
    output wordAddrT  dcacheAddr,
    output wordT      dcacheWdata,
    input  wire wordT dcacheRdata,
    input  wire       dcacheStall
);

    logic    freeze;
    logic    fetchEn;
    logic    stallDecode;
    logic    redirect;
    wordT    pc;

    wordT    ifIdInstr;
    wordT    ifIdPc;

    regAddrT decRs1;
    regAddrT decRs2;
    logic    decIsBranch;
    logic    decIsJal;
    logic    decIsJalr;
    logic    decMemRead;
    logic    decMemWrite;
    logic    decRegWrite;
    logic    decAluSrcImm;
    aluOpT   decAluOp;
    wordT    decImm;
    wordT    rfData1;
    wordT    rfData2;
    wordT    decA;
    wordT    decB;
    wordT    decLink;
    logic    branchTaken;
    wordT    targetSum;
    wordT    target;

    fwdSelT  fwdExA;
    fwdSelT  fwdExB;
    fwdSelT  fwdDecA;
    fwdSelT  fwdDecB;

    logic    exRegWrite;
    logic    exMemRead;
    logic    exMemWrite;
    logic    exIsJump;
    logic    exAluSrcImm;
    aluOpT   exAluOp;
    wordT    exImm;
    wordT    exRdata1;
    wordT    exRdata2;
    wordT    exLink;
    regAddrT exRs1;
    regAddrT exRs2;
    regAddrT exRd;
    wordT    exOpA;
    wordT    exOpBReg;
    wordT    exOpB;
    wordT    aluResult;
    wordT    exResult;

    logic    memRegWrite;
    logic    memMemRead;
    logic    memMemWrite;
    regAddrT memRd;
    wordT    memResult;
    wordT    memStoreData;

    logic    wbRegWrite;
    logic    wbMemToReg;
    regAddrT wbRd;
    wordT    wbResult;
    wordT    wbLoadData;
    wordT    wbValue;

    function automatic wordT pickOperand(
        input fwdSelT sel,
        input wordT   regVal,
        input wordT   memVal,
        input wordT   wbVal
    );
        case (sel)
            fwdMem:  return memVal;
            fwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign freeze  = icacheStall || dcacheStall;
    assign fetchEn = !freeze && !stallDecode;

    assign icacheAddr = pc[31:2];

    // decode stage
    assign decRs1  = ifIdInstr[19:15];
    assign decRs2  = ifIdInstr[24:20];
    assign decA    = pickOperand(fwdDecA, rfData1, memResult, wbValue);
    assign decB    = pickOperand(fwdDecB, rfData2, memResult, wbValue);
    assign decLink = ifIdPc + 32'd4;

    // funct3[0] turns beq into bne
    assign branchTaken = decIsBranch && ((decA == decB) != ifIdInstr[12]);
    assign redirect    = branchTaken || decIsJal || decIsJalr;
    assign targetSum   = (decIsJalr ? decA : ifIdPc) + decImm;
    assign target      = {targetSum[31:1], 1'b0};

    // execute stage
    assign exOpA    = pickOperand(fwdExA, exRdata1, memResult, wbValue);
    assign exOpBReg = pickOperand(fwdExB, exRdata2, memResult, wbValue);
    assign exOpB    = exAluSrcImm ? exImm : exOpBReg;
    assign exResult = exIsJump ? exLink : aluResult;

    // held off while fetch stalls so an access completes only once
    assign dcacheRen   = memMemRead && !icacheStall;
    assign dcacheWen   = memMemWrite && !icacheStall;
    assign dcacheAddr  = memResult[31:2];
    assign dcacheWdata = memStoreData;

    assign wbValue = wbMemToReg ? wbLoadData : wbResult;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc          <= '0;
            ifIdInstr   <= '0;
            exRegWrite  <= 1'b0;
            exMemRead   <= 1'b0;
            exMemWrite  <= 1'b0;
            exIsJump    <= 1'b0;
            memRegWrite <= 1'b0;
            memMemRead  <= 1'b0;
            memMemWrite <= 1'b0;
            wbRegWrite  <= 1'b0;
            wbMemToReg  <= 1'b0;
        end else if (!freeze) begin
            if (!stallDecode) begin
                pc        <= redirect ? target : pc + 32'd4;
                ifIdInstr <= redirect ? '0 : icacheRdata; // zero word decodes as a bubble
            end
            exRegWrite  <= decRegWrite && !stallDecode;
            exMemRead   <= decMemRead && !stallDecode;
            exMemWrite  <= decMemWrite && !stallDecode;
            exIsJump    <= (decIsJal || decIsJalr) && !stallDecode;
            memRegWrite <= exRegWrite;
            memMemRead  <= exMemRead;
            memMemWrite <= exMemWrite;
            wbRegWrite  <= memRegWrite;
            wbMemToReg  <= memMemRead;
        end
    end

    always_ff @(posedge clk) begin
        if (fetchEn) begin
            ifIdPc <= pc;
        end
        if (!freeze) begin
            exAluSrcImm  <= decAluSrcImm;
            exAluOp      <= decAluOp;
            exImm        <= decImm;
            exRdata1     <= rfData1;
            exRdata2     <= rfData2;
            exLink       <= decLink;
            exRs1        <= decRs1;
            exRs2        <= decRs2;
            exRd         <= ifIdInstr[11:7];
            memRd        <= exRd;
            memResult    <= exResult;
            memStoreData <= exOpBReg;
            wbRd         <= memRd;
            wbResult     <= memResult;
            wbLoadData   <= dcacheRdata;
        end
    end

    instrDecoder decoder (
        .instr     (ifIdInstr),
        .isBranch  (decIsBranch),
        .isJal     (decIsJal),
        .isJalr    (decIsJalr),
        .memRead   (decMemRead),
        .memWrite  (decMemWrite),
        .regWrite  (decRegWrite),
        .aluSrcImm (decAluSrcImm),
        .aluOp     (decAluOp),
        .imm       (decImm)
    );

    regFile regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs1     (decRs1),
        .rs2     (decRs2),
        .rd      (wbRd),
        .wrEn    (wbRegWrite),
        .wrData  (wbValue),
        .rdData1 (rfData1),
        .rdData2 (rfData2)
    );

    aluUnit alu (
        .opA    (exOpA),
        .opB    (exOpB),
        .aluOp  (exAluOp),
        .result (aluResult)
    );

    hazardUnit hazards (
        .decRs1      (decRs1),
        .decRs2      (decRs2),
        .exRs1       (exRs1),
        .exRs2       (exRs2),
        .exRd        (exRd),
        .memRd       (memRd),
        .wbRd        (wbRd),
        .exRegWrite  (exRegWrite),
        .exMemRead   (exMemRead),
        .memRegWrite (memRegWrite),
        .memMemRead  (memMemRead),
        .wbRegWrite  (wbRegWrite),
        .decIsBranch (decIsBranch || decIsJalr), // jalr also needs rs1 in decode
        .fwdExA      (fwdExA),
        .fwdExB      (fwdExB),
        .fwdDecA     (fwdDecA),
        .fwdDecB     (fwdDecB),
        .stallDecode (stallDecode)
    );

endmodule

`default_nettype wire

//--- verilog/rvPkg.sv
`default_nettype none

`include "rv_defines.svh"

package rvPkg;

    typedef logic [`XLEN-1:0]        wordT;
    typedef logic [`WORD_ADDR_W-1:0] wordAddrT;
    typedef logic [`REG_ADDR_W-1:0]  regAddrT;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSll,
        aluSrl,
        aluSra
    } aluOpT;

    // where an operand is taken from
    typedef enum logic [1:0] {
        fwdNone,  // register file value
        fwdMem,   // result sitting in the memory stage
        fwdWb     // writeback value
    } fwdSelT;

endpackage

`default_nettype wire

//--- verilog/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// datapath widths
`define XLEN        32
`define WORD_ADDR_W 30
`define REG_ADDR_W  5
`define NUM_REGS    32

// major opcodes, instr[6:0]
`define OP_RTYPE    7'b0110011
`define OP_ITYPE    7'b0010011
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_BRANCH   7'b1100011
`define OP_JAL      7'b1101111
`define OP_JALR     7'b1100111

`endif
